/* Makefile */
# Verilator build for the pixel window buffer

TOP = pixel_window_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* bench/pixel_window_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pw_defs.svh"

module pixel_window_tb;
   import pw_data_pkg::*;
   import pw_ctrl_pkg::*;

   // the tests take a few hundred cycles, the limit leaves a wide margin
   localparam int timeout_cycles = 2000;
   localparam int max_cols       = 16;

   logic         clk;
   logic         rst_n;
   logic         frame_start;
   group_count_t num_groups;
   logic         col_valid;
   pixel_group_u data0;
   pixel_group_u data1;
   pixel_group_u data2;
   logic         rd_en;
   group_idx_t   rd_group;
   logic         window_ready;
   logic         out_valid;
   feature_t     feature1;
   feature_t     feature2;
   feature_t     feature3;
   feature_t     feature4;

   integer       seed;
   int           errors;
   int           checks;
   int           cycle;
   int           col_count;
   pixel_group_u model_mem [max_cols][`PW_MAX_GROUPS][`PW_ROWS];
   feature_t     exp_q[$];
   int           issue_q[$];

   pixel_window uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .frame_start  (frame_start),
      .num_groups   (num_groups),
      .col_valid    (col_valid),
      .data0        (data0),
      .data1        (data1),
      .data2        (data2),
      .rd_en        (rd_en),
      .rd_group     (rd_group),
      .window_ready (window_ready),
      .out_valid    (out_valid),
      .feature1     (feature1),
      .feature2     (feature2),
      .feature3     (feature3),
      .feature4     (feature4)
   );

   always #50 clk = ~clk;

   //////////////////////////////////////////////////
   // compare tasks and reference model
   //////////////////////////////////////////////////

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_feature(input string name, input feature_t got, input feature_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   function automatic pixel_group_u random_word();
      pixel_group_u w;
      w.raw = $random(seed);
      return w;
   endfunction

   // window columns are the last three completed ones, oldest left
   function automatic feature_t expected_feature(input group_idx_t g, input int lane);
      feature_t     f;
      pixel_group_u w;
      int           base;
      base = col_count - `PW_TAPS_PER_ROW;
      for (int r = 0; r < `PW_ROWS; r++) begin
         for (int c = 0; c < `PW_TAPS_PER_ROW; c++) begin
            w = model_mem[base + c][g][r];
            f[r*`PW_TAPS_PER_ROW + c] = w.lane[lane];
         end
      end
      return f;
   endfunction

   // every out_valid must match the oldest accepted read, two edges later
   always @(negedge clk) begin
      if (rst_n && out_valid) begin
         if (issue_q.size() == 0) begin
            errors++;
            $display("ERROR at %0t: out_valid without an accepted read", $time);
         end else begin
            if (cycle - issue_q.pop_front() != 2) begin
               errors++;
               $display("ERROR at %0t: read answered with wrong latency", $time);
            end
            check_feature("feature1", feature1, exp_q.pop_front());
            check_feature("feature2", feature2, exp_q.pop_front());
            check_feature("feature3", feature3, exp_q.pop_front());
            check_feature("feature4", feature4, exp_q.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle == timeout_cycles) begin
         $display("ERROR: run did not finish within %0d cycles", timeout_cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // stimulus tasks, entered and left on a falling edge
   //////////////////////////////////////////////////

   task automatic load_column();
      for (int g = 0; g < int'(num_groups); g++) begin
         col_valid = 1'b1;
         data0     = random_word();
         data1     = random_word();
         data2     = random_word();
         if (col_count < max_cols) begin
            model_mem[col_count][g][0] = data0;
            model_mem[col_count][g][1] = data1;
            model_mem[col_count][g][2] = data2;
         end
         @(negedge clk);
      end
      col_valid = 1'b0;
      col_count++;
   endtask

   // one read cycle, an expectation only when three columns are in
   task automatic start_read(input int g);
      rd_en    = 1'b1;
      rd_group = group_idx_t'(g);
      if (col_count >= `PW_TAPS_PER_ROW) begin
         for (int k = 0; k < `PW_LANES; k++) begin
            exp_q.push_back(expected_feature(group_idx_t'(g), k));
         end
         issue_q.push_back(cycle);
      end
      @(negedge clk);
   endtask

   task automatic wait_reads_done();
      int n;
      n        = 0;
      rd_en    = 1'b0;
      while (issue_q.size() != 0 && n < 10) begin
         @(negedge clk);
         n++;
      end
      if (issue_q.size() != 0) begin
         errors++;
         $display("ERROR at %0t: accepted read never produced out_valid", $time);
         issue_q.delete();
         exp_q.delete();
      end
   endtask

   task automatic new_frame(input int groups);
      frame_start = 1'b1;
      num_groups  = group_count_t'(groups);
      @(negedge clk);
      frame_start = 1'b0;
      col_count   = 0;
   endtask

   task automatic read_all_groups();
      for (int g = 0; g < int'(num_groups); g++) begin
         start_read(g);
      end
      wait_reads_done();
   endtask

   //////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////

   task automatic test_reset_state();
      check_bit("window_ready", window_ready, 1'b0);
      check_bit("out_valid", out_valid, 1'b0);
      start_read(0);
      load_column();
      start_read(1);
      rd_en = 1'b0;
      repeat (4) @(negedge clk);
      check_bit("out_valid", out_valid, 1'b0);
      check_bit("window_ready", window_ready, 1'b0);
   endtask

   task automatic test_first_window();
      load_column();
      check_bit("window_ready", window_ready, 1'b0);
      load_column();
      check_bit("window_ready", window_ready, 1'b1);
      start_read(0);
      wait_reads_done();
      start_read(1);
      wait_reads_done();
   endtask

   task automatic test_slide();
      load_column();
      check_bit("window_ready", window_ready, 1'b1);
      read_all_groups();
      load_column();
      read_all_groups();
   endtask

   task automatic test_back_to_back();
      start_read(1);
      start_read(0);
      start_read(1);
      start_read(0);
      wait_reads_done();
   endtask

   task automatic test_all_groups();
      new_frame(8);
      repeat (4) load_column();
      read_all_groups();
   endtask

   task automatic test_frame_restart();
      new_frame(3);
      check_bit("window_ready", window_ready, 1'b0);
      repeat (2) load_column();
      check_bit("window_ready", window_ready, 1'b0);
      load_column();
      check_bit("window_ready", window_ready, 1'b1);
      read_all_groups();
   endtask

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      frame_start = 1'b0;
      num_groups  = group_count_t'(2);
      col_valid   = 1'b0;
      data0       = '0;
      data1       = '0;
      data2       = '0;
      rd_en       = 1'b0;
      rd_group    = '0;
      seed        = 32'hdcfc;
      errors      = 0;
      checks      = 0;
      cycle       = 0;
      col_count   = 0;

      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      test_reset_state();
      test_first_window();
      test_slide();
      test_back_to_back();
      test_all_groups();
      test_frame_restart();

      repeat (2) @(negedge clk);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
source/pw_data_pkg.sv
source/pw_ctrl_pkg.sv
source/window_loader.sv
source/column_bank.sv
source/column_bank_array.sv
source/window_assembler.sv
source/pixel_window.sv
bench/pixel_window_tb.sv

/* source/column_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pw_defs.svh"

module column_bank (
   input  logic                      clk,
   input  logic                      wr_en,
   input  pw_ctrl_pkg::group_idx_t   wr_group,
   input  pw_data_pkg::pixel_group_u wr_data,
   input  logic                      rd_en,
   input  pw_ctrl_pkg::group_idx_t   rd_group,
   output pw_data_pkg::pixel_group_u rd_data
);

   // one word per channel group, one row of one column
   logic [`PW_LANES*`PW_DATA_WIDTH-1:0] mem [`PW_MAX_GROUPS];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_group] <= wr_data.raw;
      end
   end

   // registered read port
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data.raw <= mem[rd_group];
      end
   end

   // no read-during-write on one address
   a_no_rw_collision : assert property (
      @(posedge clk)
      !(wr_en && rd_en && wr_group == rd_group)
   );

endmodule

`default_nettype wire

/* source/column_bank_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pw_defs.svh"

module column_bank_array (
   input  logic                                              clk,
   input  logic [`PW_BANKS-1:0]                              wr_en,
   input  pw_ctrl_pkg::group_idx_t                           wr_group,
   input  pw_data_pkg::pixel_group_u                         data0,
   input  pw_data_pkg::pixel_group_u                         data1,
   input  pw_data_pkg::pixel_group_u                         data2,
   input  logic                                              rd_fire,
   input  pw_ctrl_pkg::group_idx_t                           rd_group,
   output pw_data_pkg::pixel_group_u [`PW_ROWS*`PW_BANKS-1:0] bank_data
);
   import pw_data_pkg::*;

   pixel_group_u row_data [`PW_ROWS];

   // row r is fed by data r
   assign row_data[0] = data0;
   assign row_data[1] = data1;
   assign row_data[2] = data2;

   //////////////////////////////////////////////////
   // 3 rows by 4 banks, shared addressing
   //////////////////////////////////////////////////

   for (genvar r = 0; r < `PW_ROWS; r++) begin : g_row
      for (genvar b = 0; b < `PW_BANKS; b++) begin : g_bank
         // all twelve banks read together on rd_fire
         column_bank u_bank (
            .clk      (clk),
            .wr_en    (wr_en[b]),
            .wr_group (wr_group),
            .wr_data  (row_data[r]),
            .rd_en    (rd_fire),
            .rd_group (rd_group),
            .rd_data  (bank_data[r*`PW_BANKS + b])
         );
      end
   end

endmodule

`default_nettype wire

/* source/pixel_window.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pw_defs.svh"

module pixel_window (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      frame_start,
   input  pw_ctrl_pkg::group_count_t num_groups,
   input  logic                      col_valid,
   input  pw_data_pkg::pixel_group_u data0,
   input  pw_data_pkg::pixel_group_u data1,
   input  pw_data_pkg::pixel_group_u data2,
   input  logic                      rd_en,
   input  pw_ctrl_pkg::group_idx_t   rd_group,
   output logic                      window_ready,
   output logic                      out_valid,
   output pw_data_pkg::feature_t     feature1,
   output pw_data_pkg::feature_t     feature2,
   output pw_data_pkg::feature_t     feature3,
   output pw_data_pkg::feature_t     feature4
);
   import pw_data_pkg::*;
   import pw_ctrl_pkg::*;

   logic [`PW_BANKS-1:0]                   wr_en;
   group_idx_t                             wr_group;
   logic                                   rd_fire;
   bank_slot_t                             oldest_slot;
   pixel_group_u [`PW_ROWS*`PW_BANKS-1:0]  bank_data;

   // write side and read acceptance
   window_loader u_loader (
      .clk          (clk),
      .rst_n        (rst_n),
      .frame_start  (frame_start),
      .num_groups   (num_groups),
      .col_valid    (col_valid),
      .rd_en        (rd_en),
      .wr_en        (wr_en),
      .wr_group     (wr_group),
      .rd_fire      (rd_fire),
      .oldest_slot  (oldest_slot),
      .window_ready (window_ready)
   );

   column_bank_array u_banks (
      .clk       (clk),
      .wr_en     (wr_en),
      .wr_group  (wr_group),
      .data0     (data0),
      .data1     (data1),
      .data2     (data2),
      .rd_fire   (rd_fire),
      .rd_group  (rd_group),
      .bank_data (bank_data)
   );

   // output side
   window_assembler u_assembler (
      .clk         (clk),
      .rst_n       (rst_n),
      .frame_start (frame_start),
      .rd_fire     (rd_fire),
      .oldest_slot (oldest_slot),
      .bank_data   (bank_data),
      .out_valid   (out_valid),
      .feature1    (feature1),
      .feature2    (feature2),
      .feature3    (feature3),
      .feature4    (feature4)
   );

endmodule

`default_nettype wire

/* source/pw_ctrl_pkg.sv */
`default_nettype none

`include "pw_defs.svh"

package pw_ctrl_pkg;

   // channel group address inside a column
   typedef logic [`PW_GROUP_BITS-1:0] group_idx_t;

   // number of groups per column, 1 to 8, so one bit wider
   typedef logic [`PW_GROUP_BITS:0] group_count_t;

   // position in the bank ring
   typedef logic [$clog2(`PW_BANKS)-1:0] bank_slot_t;

   // loaded columns, saturates at the window width
   typedef logic [1:0] col_count_t;

endpackage

`default_nettype wire

/* source/pw_data_pkg.sv */
`default_nettype none

`include "pw_defs.svh"

package pw_data_pkg;

   // one channel sample
   typedef logic [`PW_DATA_WIDTH-1:0] pixel_t;

   // input word and bank word
   // raw for storage, lane for the per-channel split, lane 0 in the low bits
   typedef union packed {
      logic [`PW_LANES*`PW_DATA_WIDTH-1:0] raw;
      pixel_t [`PW_LANES-1:0]              lane;
   } pixel_group_u;

   // 3x3 feature of one channel
   // tap = row*3 + column, tap 0 in the low bits, column 0 is the oldest
   typedef pixel_t [`PW_ROWS*`PW_TAPS_PER_ROW-1:0] feature_t;

endpackage

`default_nettype wire

/* source/pw_defs.svh */
`ifndef PW_DEFS_SVH
`define PW_DEFS_SVH

//////////////////////////////////////////////////
// sample and word geometry
//////////////////////////////////////////////////

// bits per channel sample
`define PW_DATA_WIDTH 8

// channels carried by one input word
`define PW_LANES 4

//////////////////////////////////////////////////
// window and ring geometry
//////////////////////////////////////////////////

`define PW_ROWS 3
`define PW_TAPS_PER_ROW 3

// three window columns plus the one under fill
`define PW_BANKS 4

// channel groups per column, and the address width for them
`define PW_MAX_GROUPS 8
`define PW_GROUP_BITS 3

`endif

/* source/window_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pw_defs.svh"

module window_assembler (
   input  logic                                              clk,
   input  logic                                              rst_n,
   input  logic                                              frame_start,
   input  logic                                              rd_fire,
   input  pw_ctrl_pkg::bank_slot_t                           oldest_slot,
   input  pw_data_pkg::pixel_group_u [`PW_ROWS*`PW_BANKS-1:0] bank_data,
   output logic                                              out_valid,
   output pw_data_pkg::feature_t                             feature1,
   output pw_data_pkg::feature_t                             feature2,
   output pw_data_pkg::feature_t                             feature3,
   output pw_data_pkg::feature_t                             feature4
);
   import pw_data_pkg::*;
   import pw_ctrl_pkg::*;

   logic       fire_d;
   bank_slot_t slot_d;
   feature_t   feat_next [`PW_LANES];
   feature_t   feat_q    [`PW_LANES];

   // valid pipe, stage 1 lines up with the bank read register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fire_d    <= 1'b0;
         out_valid <= 1'b0;
      end else if (frame_start) begin
         fire_d    <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         fire_d    <= rd_fire;
         out_valid <= fire_d;
      end
   end

   // rotation taken with the read
   always_ff @(posedge clk) begin
      if (rd_fire) begin
         slot_d <= oldest_slot;
      end
   end

   //////////////////////////////////////////////////
   // rotation and lane split
   //////////////////////////////////////////////////

   always_comb begin
      bank_slot_t   src;
      pixel_group_u word;
      for (int c = 0; c < `PW_TAPS_PER_ROW; c++) begin
         // window column c sits c banks after the oldest
         src = slot_d + bank_slot_t'(c);
         for (int r = 0; r < `PW_ROWS; r++) begin
            word = bank_data[r*`PW_BANKS + int'(src)];
            for (int k = 0; k < `PW_LANES; k++) begin
               feat_next[k][r*`PW_TAPS_PER_ROW + c] = word.lane[k];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fire_d) begin
         for (int k = 0; k < `PW_LANES; k++) begin
            feat_q[k] <= feat_next[k];
         end
      end
   end

   // lane k drives feature k+1
   assign feature1 = feat_q[0];
   assign feature2 = feat_q[1];
   assign feature3 = feat_q[2];
   assign feature4 = feat_q[3];

   // fixed two-edge latency from the accepted read
   a_read_latency : assert property (
      @(posedge clk) disable iff (!rst_n)
      out_valid |-> $past(rd_fire, 2)
   );

endmodule

`default_nettype wire

/* source/window_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pw_defs.svh"

module window_loader (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      frame_start,
   input  pw_ctrl_pkg::group_count_t num_groups,
   input  logic                      col_valid,
   input  logic                      rd_en,
   output logic [`PW_BANKS-1:0]      wr_en,
   output pw_ctrl_pkg::group_idx_t   wr_group,
   output logic                      rd_fire,
   output pw_ctrl_pkg::bank_slot_t   oldest_slot,
   output logic                      window_ready
);
   import pw_ctrl_pkg::*;

   localparam col_count_t full_cols = col_count_t'(`PW_TAPS_PER_ROW);

   group_idx_t group_cnt;
   bank_slot_t write_slot;
   col_count_t loaded_cnt;
   logic       col_last;
   logic       load;

   // last group of the column closes it
   assign col_last = col_valid &&
                     (group_count_t'(group_cnt) == num_groups - group_count_t'(1));

   // a word arriving with frame_start belongs to no frame
   assign load = col_valid && !frame_start;

   //////////////////////////////////////////////////
   // group counter and ring position
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         group_cnt  <= '0;
         write_slot <= '0;
         loaded_cnt <= '0;
      end else if (frame_start) begin
         group_cnt  <= '0;
         write_slot <= '0;
         loaded_cnt <= '0;
      end else if (col_valid) begin
         if (col_last) begin
            group_cnt  <= '0;
            write_slot <= write_slot + bank_slot_t'(1);
            if (loaded_cnt != full_cols) begin
               loaded_cnt <= loaded_cnt + col_count_t'(1);
            end
         end else begin
            group_cnt <= group_cnt + group_idx_t'(1);
         end
      end
   end

   // set on the edge that completes the third column
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         window_ready <= 1'b0;
      end else if (frame_start) begin
         window_ready <= 1'b0;
      end else if (col_last && loaded_cnt == full_cols - col_count_t'(1)) begin
         window_ready <= 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // bank strobes and read gating
   //////////////////////////////////////////////////

   // one-hot write strobe for the bank under fill
   assign wr_en    = load ? (`PW_BANKS'(1) << write_slot) : '0;
   assign wr_group = group_cnt;

   // slot after the one being filled holds the oldest column
   assign oldest_slot = (loaded_cnt == full_cols) ? write_slot + bank_slot_t'(1) : '0;

   assign rd_fire = rd_en && window_ready;

   // num_groups out of range would never close a column
   a_groups_in_range : assert property (
      @(posedge clk) disable iff (!rst_n)
      col_valid |-> (num_groups != '0 && num_groups <= `PW_MAX_GROUPS)
   );

endmodule

`default_nettype wire
